// File: hw/rtcShadow_defines.svh
// Address map, control words and APB offsets of the RTC shadow register block
`ifndef RTC_SHADOW_DEFINES_SVH
`define RTC_SHADOW_DEFINES_SVH

// RTC register addresses of the nine shadow slots
`define RTC_SLOT_YEAR     8'h26
`define RTC_SLOT_MONTH    8'h25
`define RTC_SLOT_DAY      8'h24
`define RTC_SLOT_HOUR     8'h23
`define RTC_SLOT_MIN      8'h22
`define RTC_SLOT_SEC      8'h21
`define RTC_SLOT_THOUR    8'h43    // Countdown timer hours
`define RTC_SLOT_TMIN     8'h42
`define RTC_SLOT_TSEC     8'h41

// RTC control addresses and the words sent to them
`define RTC_ADDR_TIMERCTL 8'h00
`define RTC_ADDR_FLAGS    8'h01
`define RTC_ADDR_INIT     8'h02
`define RTC_WORD_TIMERON  8'h08    // Timer enable bit
`define RTC_WORD_FLAGDOWN 8'h04    // Clears the interrupt flags
`define RTC_WORD_INIT     8'h10    // One-shot initialisation
`define RTC_WORD_IDLE     8'hFF    // Unknown address

`define NUM_SLOTS         9

// APB slave offsets and widths
`define APB_ADDR_W        8
`define APB_DATA_W        32
`define APB_CTRL          8'h00
`define APB_EDIT          8'h04
`define APB_SLOT0         8'h08    // Year, then one slot every 4 bytes up to 8'h28
`define APB_STATUS        8'h2C

`endif

// File: hw/rtcShadowPkg.sv
// Shared types of the RTC shadow register block, used by RTL and testbench
`default_nettype none

package rtcShadowPkg;

	////////////////////////////////////////////////
	// Plain vector types

	typedef logic [7:0] bcdByte;    // Two packed BCD digits, tens in the high nibble
	typedef logic [7:0] rtcAddr;    // Register address on the RTC bus
	typedef logic [8:0] slotMask;   // One bit per shadow slot, bit 0 is the year

	////////////////////////////////////////////////
	// Slot kinds

	// Picks the wrap limits of a shadow register
	typedef enum logic [2:0]
	{
		kindYear   = 3'd0,   // 00..99
		kindMonth  = 3'd1,   // 01..12
		kindDay    = 3'd2,   // 01..31
		kindHour   = 3'd3,   // 00..23
		kindMinute = 3'd4,   // 00..59
		kindSecond = 3'd5    // 00..59
	} slotKind;

endpackage

`default_nettype wire

// File: hw/bcdComplement.sv
// Two-digit BCD subtraction of a value from a fixed maximum, for the countdown timer encoding
`default_nettype none

module bcdComplement
(
	input  rtcShadowPkg::bcdByte value,     // Subtrahend
	input  rtcShadowPkg::bcdByte maximum,   // Minuend, 23 or 59 for the timer
	output rtcShadowPkg::bcdByte result     // maximum - value in BCD
);

	logic [4:0] loRaw;      // Units difference with borrow in bit 4
	logic [4:0] hiRaw;      // Tens difference with borrow in bit 4
	logic       loBorrow;
	logic [4:0] loAdj;
	logic [4:0] hiAdj;

	// Units digit
	assign loRaw    = {1'b0, maximum[3:0]} - {1'b0, value[3:0]};
	assign loBorrow = loRaw[4];
	assign loAdj    = loBorrow ? loRaw + 5'd10 : loRaw;   // Back into 0..9

	// Tens digit takes the units borrow
	assign hiRaw = {1'b0, maximum[7:4]} - {1'b0, value[7:4]} - {4'b0000, loBorrow};
	assign hiAdj = hiRaw[4] ? hiRaw + 5'd10 : hiRaw;      // Wraps if value > maximum

	assign result = {hiAdj[3:0], loAdj[3:0]};

endmodule

`default_nettype wire

// File: hw/bcdRegister.sv
// One BCD shadow register with bus load and wrapping up/down stepping
`default_nettype none

module bcdRegister
#(
	parameter rtcShadowPkg::slotKind kind = rtcShadowPkg::kindSecond
)
(
	input  logic                 CLK,
	input  logic                 RST,
	input  logic                 stepUp,      // One-cycle edit pulses
	input  logic                 stepDown,
	input  logic                 editSel,     // This slot is under the edit pointer
	input  logic                 loadSel,     // Capture loadValue this edge
	input  rtcShadowPkg::bcdByte loadValue,
	output rtcShadowPkg::bcdByte value
);

	// Wrap limits by kind
	localparam rtcShadowPkg::bcdByte lowLimit =
		(kind == rtcShadowPkg::kindDay || kind == rtcShadowPkg::kindMonth) ? 8'h01 : 8'h00;
	localparam rtcShadowPkg::bcdByte highLimit =
		(kind == rtcShadowPkg::kindYear)  ? 8'h99 :
		(kind == rtcShadowPkg::kindMonth) ? 8'h12 :
		(kind == rtcShadowPkg::kindDay)   ? 8'h31 :
		(kind == rtcShadowPkg::kindHour)  ? 8'h23 : 8'h59;

	rtcShadowPkg::bcdByte upValue;
	rtcShadowPkg::bcdByte downValue;

	always_comb
	begin
		if (value == highLimit)
			upValue = lowLimit;                                   // Wrap to bottom
		else if (value[3:0] == 4'd9)
			upValue = {value[7:4] + 4'd1, 4'd0};                  // Carry into tens
		else
			upValue = value + 8'd1;

		if (value == lowLimit)
			downValue = highLimit;                                // Wrap to top
		else if (value[3:0] == 4'd0)
			downValue = {value[7:4] - 4'd1, 4'd9};                // Borrow from tens
		else
			downValue = value - 8'd1;
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			value <= lowLimit;
		else if (loadSel)
			value <= loadValue;                                   // RTC data wins over edits
		else if (editSel && stepUp)
			value <= upValue;
		else if (editSel && stepDown)
			value <= downValue;
	end

	function automatic logic inRange(input rtcShadowPkg::bcdByte v);
		return (v[3:0] <= 4'd9) && (v[7:4] <= 4'd9) && (v >= lowLimit) && (v <= highLimit);
	endfunction

	// A step from a legal value lands on a legal value
	stepKeepsRange: assert property (@(posedge CLK) disable iff (RST)
		(editSel && (stepUp || stepDown) && !loadSel && inRange(value)) |=> inRange(value))
		else $error("Shadow register stepped out of its BCD range");

endmodule

`default_nettype wire

// File: hw/rtcShadowBank.sv
// Nine BCD shadow registers between the RTC bus and the front panel, with outgoing byte mux
`default_nettype none
`include "rtcShadow_defines.svh"

module rtcShadowBank
(
	input  logic                                   CLK,
	input  logic                                   RST,
	input  logic                                   sendAddress,   // Sequencer drives the address
	input  logic                                   receiveData,   // Sequencer reads from the RTC
	input  logic                                   sendData,      // Sequencer writes to the RTC
	input  logic                                   irq,
	input  logic                                   alarmStop,
	input  logic                                   up,            // Front panel buttons
	input  logic                                   down,
	input  logic                 [6:0]             editPointer,   // Slot address being edited
	input  rtcShadowPkg::rtcAddr                   rtcAddress,
	input  rtcShadowPkg::bcdByte                   busIn,
	output rtcShadowPkg::bcdByte                   busOut,
	output logic                                   busOe,
	output rtcShadowPkg::bcdByte [`NUM_SLOTS-1:0]  slotValues,    // Index 0 is the year
	output logic                                   initDone
);

	// Kind of each slot, in one-hot bit order
	localparam rtcShadowPkg::slotKind slotKinds [`NUM_SLOTS] = '{
		rtcShadowPkg::kindYear, rtcShadowPkg::kindMonth,  rtcShadowPkg::kindDay,
		rtcShadowPkg::kindHour, rtcShadowPkg::kindMinute, rtcShadowPkg::kindSecond,
		rtcShadowPkg::kindHour, rtcShadowPkg::kindMinute, rtcShadowPkg::kindSecond
	};
	localparam rtcShadowPkg::bcdByte timerMax [3] = '{8'h23, 8'h59, 8'h59};   // H, M, S

	function automatic rtcShadowPkg::slotMask slotDecode(input rtcShadowPkg::rtcAddr addr);
		rtcShadowPkg::slotMask mask;
		mask = '0;
		case (addr)
			`RTC_SLOT_YEAR  : mask[0] = 1'b1;
			`RTC_SLOT_MONTH : mask[1] = 1'b1;
			`RTC_SLOT_DAY   : mask[2] = 1'b1;
			`RTC_SLOT_HOUR  : mask[3] = 1'b1;
			`RTC_SLOT_MIN   : mask[4] = 1'b1;
			`RTC_SLOT_SEC   : mask[5] = 1'b1;
			`RTC_SLOT_THOUR : mask[6] = 1'b1;
			`RTC_SLOT_TMIN  : mask[7] = 1'b1;
			`RTC_SLOT_TSEC  : mask[8] = 1'b1;
			default         : mask = '0;
		endcase
		return mask;
	endfunction

	//////////////////////////////////////////////////
	// Up/down edge pulses

	logic upPrev;
	logic downPrev;
	logic upPulse;
	logic downPulse;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			upPrev    <= 1'b0;
			downPrev  <= 1'b0;
			upPulse   <= 1'b0;
			downPulse <= 1'b0;
		end
		else
		begin
			upPrev    <= up;
			downPrev  <= down;
			upPulse   <= up && !upPrev;       // Held button gives one step
			downPulse <= down && !downPrev;
		end
	end

	//////////////////////////////////////////////////
	// Edit and load selects

	rtcShadowPkg::slotMask editSel;
	rtcShadowPkg::slotMask loadSel;

	assign editSel = slotDecode({1'b0, editPointer});

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			loadSel <= '0;
		else if (receiveData)
			loadSel <= slotDecode(rtcAddress);   // Register captures busIn next edge
		else
			loadSel <= '0;
	end

	//////////////////////////////////////////////////
	// Timer encoding and shadow registers

	rtcShadowPkg::bcdByte [2:0]            timerIn;    // Complemented bus value
	rtcShadowPkg::bcdByte [2:0]            timerOut;   // Complemented register value
	rtcShadowPkg::bcdByte [`NUM_SLOTS-1:0] loadValues;

	genvar t;
	for (t = 0; t < 3; t++)
	begin : genTimer
		bcdComplement inComp
		(
			.value   (busIn),
			.maximum (timerMax[t]),
			.result  (timerIn[t])
		);
		bcdComplement outComp
		(
			.value   (slotValues[6+t]),
			.maximum (timerMax[t]),
			.result  (timerOut[t])
		);
	end

	always_comb
	begin
		for (int i = 0; i < 6; i++)
			loadValues[i] = busIn;                         // Date and time as received
		for (int j = 0; j < 3; j++)
			loadValues[6+j] = irq ? timerIn[j] : 8'h00;    // Timer idle reads as zero
	end

	genvar s;
	for (s = 0; s < `NUM_SLOTS; s++)
	begin : genSlot
		bcdRegister #(.kind(slotKinds[s])) slotReg
		(
			.CLK       (CLK),
			.RST       (RST),
			.stepUp    (upPulse),
			.stepDown  (downPulse),
			.editSel   (editSel[s]),
			.loadSel   (loadSel[s]),
			.loadValue (loadValues[s]),
			.value     (slotValues[s])
		);
	end

	//////////////////////////////////////////////////
	// Outgoing byte

	rtcShadowPkg::bcdByte dataOut;
	logic                 sendDataPrev;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			sendDataPrev <= 1'b0;
			initDone     <= 1'b0;
		end
		else
		begin
			sendDataPrev <= sendData;
			if (sendDataPrev && !sendData)
				initDone <= 1'b1;                      // Sticky until reset
		end
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			dataOut <= 8'h00;
		else
			case (rtcAddress)
				`RTC_ADDR_TIMERCTL : dataOut <= (!irq || alarmStop) ? 8'h00 : `RTC_WORD_TIMERON;
				`RTC_ADDR_FLAGS    : dataOut <= `RTC_WORD_FLAGDOWN;
				`RTC_ADDR_INIT     : dataOut <= initDone ? 8'h00 : `RTC_WORD_INIT;
				`RTC_SLOT_YEAR     : dataOut <= slotValues[0];
				`RTC_SLOT_MONTH    : dataOut <= slotValues[1];
				`RTC_SLOT_DAY      : dataOut <= slotValues[2];
				`RTC_SLOT_HOUR     : dataOut <= slotValues[3];
				`RTC_SLOT_MIN      : dataOut <= slotValues[4];
				`RTC_SLOT_SEC      : dataOut <= slotValues[5];
				`RTC_SLOT_THOUR    : dataOut <= timerOut[0];   // Back to RTC countdown form
				`RTC_SLOT_TMIN     : dataOut <= timerOut[1];
				`RTC_SLOT_TSEC     : dataOut <= timerOut[2];
				default            : dataOut <= `RTC_WORD_IDLE;
			endcase
	end

	assign busOe  = sendData || sendAddress;
	assign busOut = sendAddress ? rtcAddress : dataOut;

	// A load select only follows a receive cycle and names one slot
	loadFromReceive: assert property (@(posedge CLK) disable iff (RST)
		(|loadSel) |-> ($past(receiveData) && $onehot(loadSel)))
		else $error("Load select without a receive or with several slots");

	busDirection: assert property (@(posedge CLK) disable iff (RST)
		!(sendAddress && sendData))
		else $error("Address and data driven onto the RTC bus together");

endmodule

`default_nettype wire

// File: hw/rtcApbConfig.sv
// APB slave with the control and edit-pointer registers and read-back of the shadow slots
`default_nettype none
`include "rtcShadow_defines.svh"

module rtcApbConfig
(
	input  logic                                   CLK,
	input  logic                                   RST,
	input  logic                                   pSel,
	input  logic                                   pEnable,
	input  logic                                   pWrite,
	input  logic                 [`APB_ADDR_W-1:0] pAddr,
	input  logic                 [`APB_DATA_W-1:0] pWData,
	output logic                 [`APB_DATA_W-1:0] pRData,
	output logic                                   pReady,
	output logic                                   pSlvErr,
	input  rtcShadowPkg::bcdByte [`NUM_SLOTS-1:0]  slotValues,
	input  logic                                   initDone,
	output logic                 [6:0]             editPointer,
	output logic                                   alarmStop
);

	//////////////////////////////////////////////////
	// Offset decode

	logic                   access;       // Access phase of a transfer
	logic                   isCtrl;
	logic                   isEdit;
	logic                   isStatus;
	logic                   isSlot;
	logic [`APB_ADDR_W-1:0] slotOffset;
	logic [3:0]             slotIndex;
	logic                   writable;
	logic                   readable;

	assign access     = pSel && pEnable;
	assign isCtrl     = (pAddr == `APB_CTRL);
	assign isEdit     = (pAddr == `APB_EDIT);
	assign isStatus   = (pAddr == `APB_STATUS);
	assign slotOffset = pAddr - `APB_SLOT0;                  // Wraps high below SLOT0
	assign slotIndex  = slotOffset[5:2];
	assign isSlot     = (slotOffset[1:0] == 2'b00) &&
		(slotOffset[`APB_ADDR_W-1:2] < (`APB_ADDR_W-2)'(`NUM_SLOTS));
	assign writable   = isCtrl || isEdit;                    // Slots and status are read-only
	assign readable   = isCtrl || isEdit || isStatus || isSlot;

	//////////////////////////////////////////////////
	// Writable registers

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			alarmStop   <= 1'b0;
			editPointer <= '0;
		end
		else if (access && pWrite)
		begin
			if (isCtrl)
				alarmStop <= pWData[0];
			if (isEdit)
				editPointer <= pWData[6:0];
		end
	end

	//////////////////////////////////////////////////
	// Read data and response

	always_comb
	begin
		pRData = '0;
		if (isCtrl)
			pRData[0] = alarmStop;
		else if (isEdit)
			pRData[6:0] = editPointer;
		else if (isStatus)
			pRData[0] = initDone;
		else if (isSlot)
			pRData[7:0] = slotValues[slotIndex];
	end

	assign pReady  = 1'b1;                                   // Zero wait states
	assign pSlvErr = access && (pWrite ? !writable : !readable);

	// Access phase only inside a selected transfer
	enableNeedsSel: assert property (@(posedge CLK) disable iff (RST)
		pEnable |-> pSel)
		else $error("pEnable high without pSel");

endmodule

`default_nettype wire

// File: hw/rtcShadowTop.sv
// RTC shadow register block with its APB configuration slave
`default_nettype none
`include "rtcShadow_defines.svh"

module rtcShadowTop
(
	input  logic                         CLK,
	input  logic                         RST,
	// APB slave
	input  logic                         pSel,
	input  logic                         pEnable,
	input  logic                         pWrite,
	input  logic     [`APB_ADDR_W-1:0]   pAddr,
	input  logic     [`APB_DATA_W-1:0]   pWData,
	output logic     [`APB_DATA_W-1:0]   pRData,
	output logic                         pReady,
	output logic                         pSlvErr,
	// RTC side
	input  logic                         sendAddress,
	input  logic                         receiveData,
	input  logic                         sendData,
	input  logic                         irq,
	input  rtcShadowPkg::rtcAddr         rtcAddress,
	input  rtcShadowPkg::bcdByte         busIn,
	input  logic                         up,
	input  logic                         down,
	output rtcShadowPkg::bcdByte         busOut,
	output logic                         busOe
);

	logic                                  alarmStop;
	logic                 [6:0]            editPointer;
	logic                                  initDone;
	rtcShadowPkg::bcdByte [`NUM_SLOTS-1:0] slotValues;   // Read back over APB

	rtcShadowBank bank
	(
		.CLK         (CLK),
		.RST         (RST),
		.sendAddress (sendAddress),
		.receiveData (receiveData),
		.sendData    (sendData),
		.irq         (irq),
		.alarmStop   (alarmStop),
		.up          (up),
		.down        (down),
		.editPointer (editPointer),
		.rtcAddress  (rtcAddress),
		.busIn       (busIn),
		.busOut      (busOut),
		.busOe       (busOe),
		.slotValues  (slotValues),
		.initDone    (initDone)
	);

	rtcApbConfig apbConfig
	(
		.CLK         (CLK),
		.RST         (RST),
		.pSel        (pSel),
		.pEnable     (pEnable),
		.pWrite      (pWrite),
		.pAddr       (pAddr),
		.pWData      (pWData),
		.pRData      (pRData),
		.pReady      (pReady),
		.pSlvErr     (pSlvErr),
		.slotValues  (slotValues),
		.initDone    (initDone),
		.editPointer (editPointer),
		.alarmStop   (alarmStop)
	);

endmodule

`default_nettype wire

// File: testbench/rtcShadowChecker.sv
// Response checker of the RTC shadow testbench, compares DUT outputs and keeps the counts
`default_nettype none

module rtcShadowChecker
(
	input  logic         CLK,
	input  logic [31:0]  pRData,
	input  logic         pReady,
	input  logic         pSlvErr,
	input  logic [7:0]   busOut,
	input  logic         busOe,
	input  logic         checkRData,    // One strobe per test from the driver
	input  logic         checkSlvErr,
	input  logic         checkBus,
	input  logic [31:0]  expected,
	input  logic [127:0] testName,
	output int           passCount,
	output int           failCount
);

	timeunit 1ns;
	timeprecision 100ps;

	int passes   = 0;
	int failures = 0;

	assign passCount = passes;
	assign failCount = failures;

	// Falling edge sits between input changes and the next rising edge
	always @(negedge CLK)
	begin : compare
		logic [31:0] actual;
		logic        failed;
		if (checkRData || checkSlvErr || checkBus)
		begin
			failed = 1'b0;
			if ((checkRData || checkSlvErr) && !pReady)
			begin
				$display("%0s: pReady low in the APB access phase", testName);
				failed = 1'b1;
			end
			if ((checkRData || checkSlvErr) && busOe)
			begin
				$display("%0s: busOe high while the RTC bus is idle", testName);
				failed = 1'b1;
			end
			if (checkRData && pSlvErr)
			begin
				$display("%0s: slave error on a read of a mapped offset", testName);
				failed = 1'b1;
			end
			if (checkBus && !busOe)
			begin
				$display("%0s: busOe low while the RTC bus is driven", testName);
				failed = 1'b1;
			end

			if (checkRData)
				actual = pRData;
			else if (checkSlvErr)
				actual = {31'h0, pSlvErr};      // Error flag as the value
			else
				actual = {24'h0, busOut};

			if (actual !== expected)
			begin
				$display("mismatch %0s expected 0x%02h actual 0x%02h", testName, expected, actual);
				failed = 1'b1;
			end

			if (failed)
				failures = failures + 1;
			else
			begin
				passes = passes + 1;
				$display("pass %0s 0x%02h", testName, actual);
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/rtcShadowTb.sv
// Testbench top of the RTC shadow block, runs the golden test table against the DUT
`default_nettype none
`include "rtcShadow_defines.svh"

module rtcShadowTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int resetCycles   = 8;
	localparam int cyclesPerTest = 12;      // Longest test is the held step, about 10 cycles

	logic         CLK;
	logic         RST;
	logic         pSel;
	logic         pEnable;
	logic         pWrite;
	logic [7:0]   pAddr;
	logic [31:0]  pWData;
	logic [31:0]  pRData;
	logic         pReady;
	logic         pSlvErr;
	logic         sendAddress;
	logic         receiveData;
	logic         sendData;
	logic         irq;
	logic [7:0]   rtcAddress;
	logic [7:0]   busIn;
	logic         up;
	logic         down;
	logic [7:0]   busOut;
	logic         busOe;

	// Strobes and expected value handed to the checker
	logic         checkRData;
	logic         checkSlvErr;
	logic         checkBus;
	logic [31:0]  expected;
	logic [127:0] testName;
	int           passCount;
	int           failCount;

	// Golden table, one entry per test
	logic [127:0] names [$];
	string        ops [$];
	logic [31:0]  arg0s [$];
	logic [31:0]  arg1s [$];
	logic [31:0]  arg2s [$];
	logic [31:0]  expects [$];
	int           setupErrors  = 0;
	int           cycleCount   = 0;
	int           timeoutLimit = 0;

	rtcShadowTop uut
	(
		.CLK(CLK), .RST(RST),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr), .pWData(pWData),
		.pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr),
		.sendAddress(sendAddress), .receiveData(receiveData), .sendData(sendData),
		.irq(irq), .rtcAddress(rtcAddress), .busIn(busIn), .up(up), .down(down),
		.busOut(busOut), .busOe(busOe)
	);

	rtcShadowChecker responseCheck
	(
		.CLK(CLK), .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr),
		.busOut(busOut), .busOe(busOe),
		.checkRData(checkRData), .checkSlvErr(checkSlvErr), .checkBus(checkBus),
		.expected(expected), .testName(testName),
		.passCount(passCount), .failCount(failCount)
	);

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;                  // 4 ns period
	end

	// Ends a stuck run
	always @(posedge CLK)
	begin
		cycleCount = cycleCount + 1;
		if (timeoutLimit != 0 && cycleCount >= timeoutLimit)
		begin
			$display("Timeout: run still busy after %0d cycles", cycleCount);
			$display("TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers

	task automatic nextCycle();
		@(posedge CLK);
		#1;                                     // Inputs move just after the edge
	endtask

	function automatic logic [7:0] randomBcd();
		return {4'($urandom % 10), 4'($urandom % 10)};
	endfunction

	// APB read-back offset of a slot, in year..tsec order
	function automatic logic [7:0] slotOffsetOf(input logic [7:0] addr);
		logic [7:0] index;
		case (addr)
			`RTC_SLOT_YEAR  : index = 8'd0;
			`RTC_SLOT_MONTH : index = 8'd1;
			`RTC_SLOT_DAY   : index = 8'd2;
			`RTC_SLOT_HOUR  : index = 8'd3;
			`RTC_SLOT_MIN   : index = 8'd4;
			`RTC_SLOT_SEC   : index = 8'd5;
			`RTC_SLOT_THOUR : index = 8'd6;
			`RTC_SLOT_TMIN  : index = 8'd7;
			default         : index = 8'd8;   // Timer seconds
		endcase
		return `APB_SLOT0 + (index << 2);
	endfunction

	task automatic readGolden();
		int           fd;
		int           fields;
		string        line;
		logic [127:0] name;
		string        op;
		logic [31:0]  a0;
		logic [31:0]  a1;
		logic [31:0]  a2;
		logic [31:0]  ex;
		fd = $fopen("testbench/rtcShadowGolden.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the golden test file");
			setupErrors++;
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line[0] == "#")
				continue;                       // Column notes and blank lines
			fields = $sscanf(line, "%s %s %h %h %h %h", name, op, a0, a1, a2, ex);
			if (fields != 6)
			begin
				$display("Golden line with %0d fields instead of 6: %s", fields, line);
				setupErrors++;
			end
			else
			begin
				names.push_back(name);
				ops.push_back(op);
				arg0s.push_back(a0);
				arg1s.push_back(a1);
				arg2s.push_back(a2);
				expects.push_back(ex);
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// Bus operations

	// Setup then access phase; the checker samples in the access phase
	task automatic apbTransfer(input logic write, input logic [7:0] offset,
			input logic [31:0] data, input logic checkIt, input logic [31:0] expValue);
		pSel    = 1'b1;
		pEnable = 1'b0;
		pWrite  = write;
		pAddr   = offset;
		pWData  = data;
		nextCycle();
		pEnable     = 1'b1;
		expected    = expValue;
		checkRData  = checkIt && !write;
		checkSlvErr = checkIt && write;       // Write tests compare the error flag
		nextCycle();
		pSel        = 1'b0;
		pEnable     = 1'b0;
		pWrite      = 1'b0;
		checkRData  = 1'b0;
		checkSlvErr = 1'b0;
	endtask

	// Select registers on the first edge, slot captures busIn on the second
	task automatic rtcLoad(input logic [7:0] addr, input logic [7:0] value,
			input logic irqLevel, input logic [31:0] expValue);
		rtcAddress  = addr;
		busIn       = value;
		irq         = irqLevel;
		receiveData = 1'b1;
		nextCycle();
		receiveData = 1'b0;                    // busIn and irq held one more edge
		nextCycle();
		apbTransfer(1'b0, slotOffsetOf(addr), 32'h0, 1'b1, expValue);
	endtask

	// Direction 0 taps up, 1 taps down, 2 holds up for several cycles
	task automatic stepSlot(input logic [7:0] addr, input logic [1:0] direction,
			input logic [31:0] expValue);
		apbTransfer(1'b1, `APB_EDIT, {24'h0, addr}, 1'b0, 32'h0);
		if (direction == 2'd1)
			down = 1'b1;
		else
			up = 1'b1;
		nextCycle();
		if (direction == 2'd2)
			repeat (3) nextCycle();
		up   = 1'b0;
		down = 1'b0;
		nextCycle();
		nextCycle();                            // Pulse has stepped the slot
		apbTransfer(1'b0, slotOffsetOf(addr), 32'h0, 1'b1, expValue);
	endtask

	// Mode 1 is an address phase, mode 0 a data phase ended by a sendData fall
	task automatic rtcSend(input logic [7:0] addr, input logic mode, input logic irqLevel,
			input logic [31:0] expValue);
		rtcAddress = addr;
		irq        = irqLevel;
		expected   = expValue;
		if (mode)
		begin
			sendAddress = 1'b1;
			checkBus    = 1'b1;                // Address passes straight through
			nextCycle();
		end
		else
		begin
			sendData = 1'b1;
			nextCycle();                        // dataOut follows the address
			checkBus = 1'b1;
			nextCycle();
		end
		checkBus    = 1'b0;
		sendAddress = 1'b0;
		sendData    = 1'b0;
		nextCycle();
	endtask

	task automatic runTest(input int idx);
		logic [7:0]  value;
		logic [31:0] expValue;
		testName = names[idx];
		value    = arg1s[idx][7:0];
		expValue = expects[idx];
		if (ops[idx] == "rtcLoad" && arg1s[idx] == 32'h100)
		begin
			value = randomBcd();                // Marker 100 asks for a random BCD byte
			if (expValue == 32'h100)
				expValue = {24'h0, value};
		end
		if (ops[idx] == "apbWrite")
			apbTransfer(1'b1, arg0s[idx][7:0], arg1s[idx], 1'b1, expValue);
		else if (ops[idx] == "apbRead")
			apbTransfer(1'b0, arg0s[idx][7:0], 32'h0, 1'b1, expValue);
		else if (ops[idx] == "rtcLoad")
			rtcLoad(arg0s[idx][7:0], value, arg2s[idx][0], expValue);
		else if (ops[idx] == "step")
			stepSlot(arg0s[idx][7:0], arg1s[idx][1:0], expValue);
		else if (ops[idx] == "rtcSend")
			rtcSend(arg0s[idx][7:0], arg1s[idx][0], arg2s[idx][0], expValue);
		else
		begin
			$display("Test %0s has an unknown operation %s", names[idx], ops[idx]);
			setupErrors++;
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial
	begin
		void'($urandom(34599));
		RST         = 1'b1;
		pSel        = 1'b0;
		pEnable     = 1'b0;
		pWrite      = 1'b0;
		pAddr       = 8'h00;
		pWData      = 32'h0;
		sendAddress = 1'b0;
		receiveData = 1'b0;
		sendData    = 1'b0;
		irq         = 1'b0;
		rtcAddress  = 8'h00;
		busIn       = 8'h00;
		up          = 1'b0;
		down        = 1'b0;
		checkRData  = 1'b0;
		checkSlvErr = 1'b0;
		checkBus    = 1'b0;
		expected    = 32'h0;
		testName    = '0;
		readGolden();
		timeoutLimit = names.size() * cyclesPerTest + resetCycles;
		repeat (resetCycles) @(posedge CLK);
		#1;
		RST = 1'b0;
		nextCycle();
		for (int i = 0; i < names.size(); i++)
			runTest(i);
		nextCycle();
		$display("Summary: %0d passed, %0d failed, %0d setup errors, %0d tests",
			passCount, failCount, setupErrors, names.size());
		if (setupErrors == 0 && failCount == 0 && names.size() > 0 && passCount == names.size())
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/rtcShadowGolden.txt
# Columns: name operation arg0 arg1 arg2 expected, numbers in hex, 100 marks a random BCD byte
# rtcLoad addr busIn irq | rtcSend addr mode(0 data 1 address) irq | step slot dir(0 up 1 down 2 held) 0 | apbWrite offset data 0 (expected pSlvErr) | apbRead offset 0 0
loadYear   rtcLoad  26 100 0 100
loadMonth  rtcLoad  25 11  0 11
loadDay    rtcLoad  24 100 0 100
loadHour   rtcLoad  23 17  0 17
loadMin    rtcLoad  22 59  0 59
loadSec    rtcLoad  21 45  0 45
initWord   rtcSend  02 0   0 10
initStatus apbRead  2C 0   0 1
initAfter  rtcSend  02 0   0 00
tHourLoad  rtcLoad  43 05  1 18
tHourSend  rtcSend  43 0   1 05
tMinIdle   rtcLoad  42 37  0 00
tMinSend   rtcSend  42 0   0 59
tSecLoad   rtcLoad  41 12  1 47
minUpWrap  step     22 0   0 00
minHeld    step     22 2   0 01
secDown    step     21 1   0 44
monthOne   rtcLoad  25 01  0 01
monthDown  step     25 1   0 12
timerOn    rtcSend  00 0   1 08
alarmStop  apbWrite 00 1   0 0
timerOff   rtcSend  00 0   1 00
flagsWord  rtcSend  01 0   0 04
unmapped   rtcSend  30 0   0 FF
addrPhase  rtcSend  43 1   0 43
slotWrite  apbWrite 14 99  0 1
hourKept   apbRead  14 0   0 17

// File: compile.f
+incdir+hw
hw/rtcShadowPkg.sv
hw/bcdComplement.sv
hw/bcdRegister.sv
hw/rtcShadowBank.sv
hw/rtcApbConfig.sv
hw/rtcShadowTop.sv
testbench/rtcShadowChecker.sv
testbench/rtcShadowTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the RTC shadow testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
	--top-module rtcShadowTb -f compile.f \
	&& ./obj_dir/VrtcShadowTb > sim.log \
	|| { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "^TESTS PASSED$" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
